/* src.f */
logic/frame_pkg.sv
logic/blk_row_sequencer.sv
logic/frame_addr_gen.sv
logic/apb_frame_reader.sv
logic/frame_ram_arbiter.sv
logic/frame_ram.sv
logic/display_frame_buffer.sv
tb/tb_clock.sv
tb/tb_display_frame_buffer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator and run, status follows the testbench verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
	--top-module tb_display_frame_buffer \
	-f src.f --Mdir obj_dir -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -F '** PASS **' > /dev/null &&
echo "simulation passed" ||
{
	echo "simulation failed"
	exit 1
}

/* tb/tb_display_frame_buffer.sv */
// drives rows and APB transfers on the falling edge
// expected addresses come from the pixel geometry of the frame
// the first failed check ends the run
`timescale 1ns/1ps

module tb_display_frame_buffer
	import frame_pkg::*;
();

	localparam int ROWS_PER_MB      = BLKS_PER_MB * ROWS_PER_BLK;
	localparam int LUMA_ROW_WORDS   = MB_COLS * 16 / 4;   // 176 pixels, 4 per word
	localparam int CHROMA_ROW_WORDS = MB_COLS * 8 / 4;
	localparam int CB_PLANE_START   = MB_ROWS * 16 * LUMA_ROW_WORDS;
	localparam int CR_PLANE_START   = CB_PLANE_START + MB_ROWS * 8 * CHROMA_ROW_WORDS;
	localparam int PLANNED_CYCLES   = 16 + 4 * ROWS_PER_MB + 16 * 4 + 32;
	localparam int READ_LIMIT       = ROWS_PER_MB + 4;   // one full stream ahead of a read

	logic        clk;
	logic        reset_n;
	logic        row_valid;
	pix_word_t   row_data;
	mb_num_t     mb_h;
	mb_num_t     mb_v;
	logic        end_of_mb;
	logic        end_of_frame;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [15:0] paddr;
	pix_word_t   pwdata;
	pix_word_t   prdata;
	logic        pready;
	logic        pslverr;

	logic        last_row_mark;   // travels with the 96th row
	logic        last_mb_mark;    // row belongs to macroblock (10,8)
	logic        rows_seen;
	int          eom_count;
	int          eof_count;
	int          rd_wait;
	integer      seed;
	string       test_name;
	pix_word_t   exp_mem [int];

	tb_clock i_tb_clock (
		.clk     (clk),
		.reset_n (reset_n)
	);

	display_frame_buffer i_display_frame_buffer (
		.clk          (clk),
		.reset_n      (reset_n),
		.row_valid    (row_valid),
		.row_data     (row_data),
		.mb_h         (mb_h),
		.mb_v         (mb_v),
		.end_of_mb    (end_of_mb),
		.end_of_frame (end_of_frame),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr)
	);

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic compare_word(input string what, input pix_word_t exp, input pix_word_t act);
		assert (act == exp)
		else
			stop_on_error($sformatf("mismatch %s %s expected %h actual %h",
				test_name, what, exp, act));
	endtask

	task automatic verify_value(input string what, input int exp, input int act);
		assert (act == exp)
		else
			stop_on_error($sformatf("mismatch %s %s expected %0d actual %0d",
				test_name, what, exp, act));
	endtask

	// word address from pixel position, planes stacked luma, Cb, Cr
	function automatic int ref_word_addr(input int h, input int v, input int blk, input int row);
		int col;
		int pix_row;
		int idx;
		if (blk < 16)
		begin
			col     = h * 4 + blk % 4;
			pix_row = v * 16 + (blk / 4) * 4 + row;
			return pix_row * LUMA_ROW_WORDS + col;
		end
		idx     = (blk - 16) % 4;
		col     = h * 2 + idx % 2;
		pix_row = v * 8 + (idx / 2) * 4 + row;
		return ((blk < 20) ? CB_PLANE_START : CR_PLANE_START) + pix_row * CHROMA_ROW_WORDS + col;
	endfunction

	// one macroblock of random rows, optional idle gaps
	task automatic write_mb(input int h, input int v, input logic gaps);
		int        addr;
		pix_word_t word;
		for (int b = 0; b < BLKS_PER_MB; b++)
		begin
			for (int r = 0; r < ROWS_PER_BLK; r++)
			begin
				if (gaps && (($random(seed) & 3) == 0))
				begin
					row_valid     = 1'b0;
					last_row_mark = 1'b0;
					@(negedge clk);
				end
				word          = $random(seed);
				addr          = ref_word_addr(h, v, b, r);
				exp_mem[addr] = word;
				row_valid     = 1'b1;
				row_data      = word;
				// position only counts on the first row, noise elsewhere
				mb_h          = (b == 0 && r == 0) ? mb_num_t'(h) : mb_num_t'($random(seed));
				mb_v          = (b == 0 && r == 0) ? mb_num_t'(v) : mb_num_t'($random(seed));
				last_row_mark = (b == BLKS_PER_MB - 1) && (r == ROWS_PER_BLK - 1);
				last_mb_mark  = (h == LAST_MB_H) && (v == LAST_MB_V);
				rows_seen     = 1'b1;
				@(negedge clk);
			end
		end
		row_valid     = 1'b0;
		last_row_mark = 1'b0;
	endtask

	task automatic apb_transfer(input logic write, input int word_addr, input pix_word_t wdata,
		output pix_word_t rdata, output logic err, output int waits);
		waits   = 0;
		psel    = 1'b1;    // setup phase
		penable = 1'b0;
		pwrite  = write;
		paddr   = 16'(word_addr * 4);
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		while (!pready)
		begin
			waits++;
			@(negedge clk);
		end
		rdata = prdata;
		err   = pslverr;
		@(negedge clk);    // completes on the rising edge in between
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic read_back(input int h, input int v, input int blk, input int row);
		int        addr;
		pix_word_t data;
		logic      err;
		int        waits;
		addr = ref_word_addr(h, v, blk, row);
		if (!exp_mem.exists(addr))
			stop_on_error($sformatf("%s: nothing was written at word %0d", test_name, addr));
		apb_transfer(1'b0, addr, '0, data, err, waits);
		verify_value("pslverr", 0, int'(err));
		compare_word($sformatf("word %0d", addr), exp_mem[addr], data);
	endtask

	// ------------------------------------------------------------------------
	// pulse counters and read wait monitor
	// ------------------------------------------------------------------------
	always @(posedge clk)
	begin
		if (!reset_n)
		begin
			eom_count <= 0;
			eof_count <= 0;
			rd_wait   <= 0;
		end
		else
		begin
			if (end_of_mb)
				eom_count <= eom_count + 1;
			if (end_of_frame)
				eof_count <= eof_count + 1;
			if (psel && penable && !pready)
				rd_wait <= rd_wait + 1;
			else
				rd_wait <= 0;
		end
	end

	a_quiet_before_rows: assert property (@(posedge clk) disable iff (!reset_n)
		!rows_seen |-> !end_of_mb && !end_of_frame)
		else stop_on_error("end pulse seen before any row was written");

	a_no_ready_when_idle: assert property (@(posedge clk) disable iff (!reset_n)
		!psel |-> !pready && !pslverr)
		else stop_on_error("pready or pslverr raised without a transfer");

	// pulse one cycle after the write of the 96th row
	a_end_after_last: assert property (@(posedge clk) disable iff (!reset_n)
		$past(row_valid && last_row_mark, 2) |->
			(end_of_mb == !$past(last_mb_mark, 2)) && (end_of_frame == $past(last_mb_mark, 2)))
		else stop_on_error("wrong end pulse after the last row of a macroblock");

	a_end_only_after_last: assert property (@(posedge clk) disable iff (!reset_n)
		(end_of_mb || end_of_frame) |-> $past(row_valid && last_row_mark, 2))
		else stop_on_error("end pulse without a completed macroblock");

	a_writer_first: assert property (@(posedge clk) disable iff (!reset_n)
		$past(row_valid, 2) |-> !pready || pslverr)
		else stop_on_error("read data returned while rows were being written");

	a_read_bounded: assert property (@(posedge clk) disable iff (!reset_n)
		rd_wait <= READ_LIMIT)
		else stop_on_error("APB transfer waited too long for pready");

	initial
	begin
		repeat (4 * PLANNED_CYCLES) @(posedge clk);
		stop_on_error("watchdog expired before the tests finished");
	end

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------
	initial
	begin
		pix_word_t data;
		logic      err;
		int        waits;
		int        addr;
		seed          = 32'hd04b;
		test_name     = "reset";
		row_valid     = 1'b0;
		row_data      = '0;
		mb_h          = '0;
		mb_v          = '0;
		psel          = 1'b0;
		penable       = 1'b0;
		pwrite        = 1'b0;
		paddr         = '0;
		pwdata        = '0;
		last_row_mark = 1'b0;
		last_mb_mark  = 1'b0;
		rows_seen     = 1'b0;

		@(posedge reset_n);
		@(negedge clk);
		repeat (4)
		begin
			verify_value("end_of_mb", 0, int'(end_of_mb));
			verify_value("end_of_frame", 0, int'(end_of_frame));
			verify_value("pready", 0, int'(pready));
			verify_value("pslverr", 0, int'(pslverr));
			@(negedge clk);
		end

		test_name = "mb_3_2_readback";
		write_mb(3, 2, 1'b1);
		repeat (4) @(negedge clk);
		read_back(3, 2, 5, 0);     // luma
		read_back(3, 2, 5, 3);
		read_back(3, 2, 17, 0);    // Cb upper right
		read_back(3, 2, 17, 3);
		read_back(3, 2, 22, 0);    // Cr lower left
		read_back(3, 2, 22, 3);
		verify_value("end_of_mb pulses", 1, eom_count);
		verify_value("end_of_frame pulses", 0, eof_count);

		test_name = "end_pulses";
		write_mb(10, 8, 1'b0);
		repeat (4) @(negedge clk);
		verify_value("end_of_mb pulses", 1, eom_count);
		verify_value("end_of_frame pulses", 1, eof_count);
		read_back(10, 8, 23, 3);   // last word of the frame

		test_name = "read_during_stream";
		addr = ref_word_addr(3, 2, 10, 2);
		fork
			write_mb(4, 2, 1'b0);
			apb_transfer(1'b0, addr, '0, data, err, waits);
		join
		verify_value("pslverr", 0, int'(err));
		compare_word($sformatf("word %0d", addr), exp_mem[addr], data);
		if (waits < ROWS_PER_MB)
			stop_on_error("read finished before the row stream ended");
		repeat (4) @(negedge clk);
		read_back(4, 2, 19, 1);
		verify_value("end_of_mb pulses", 2, eom_count);

		test_name = "error_response";
		addr = ref_word_addr(3, 2, 0, 0);
		apb_transfer(1'b1, addr, ~exp_mem[addr], data, err, waits);
		verify_value("write pslverr", 1, int'(err));
		verify_value("write access cycles", 0, waits);
		read_back(3, 2, 0, 0);     // word must be unchanged
		apb_transfer(1'b0, FRAME_WORDS, '0, data, err, waits);
		verify_value("range pslverr", 1, int'(err));
		verify_value("range access cycles", 0, waits);

		repeat (2) @(negedge clk);
		$display("** PASS **");
		$finish;
	end

endmodule

/* tb/tb_clock.sv */
// testbench clock and reset, 4 ns period
// reset_n is held low for 16 cycles and released on a falling edge
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset_n
);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;    // 2 ns half period
	end

	initial
	begin
		reset_n = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
	end

endmodule

/* logic/display_frame_buffer.sv */
// display frame buffer, deblocking bypass path only
// rows in, frame RAM inside, host reads over APB with the writer having priority
`timescale 1ns/1ps

module display_frame_buffer
	import frame_pkg::*;
(
	input  logic        clk,
	input  logic        reset_n,
	// reconstructed rows
	input  logic        row_valid,
	input  pix_word_t   row_data,
	input  mb_num_t     mb_h,
	input  mb_num_t     mb_v,
	output logic        end_of_mb,
	output logic        end_of_frame,
	// APB slave
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [15:0] paddr,
	input  pix_word_t   pwdata,
	output pix_word_t   prdata,
	output logic        pready,
	output logic        pslverr
);

	blk_pos_t  pos;
	logic      pos_valid;
	pix_word_t pos_data;
	ram_req_t  wr_req;
	ram_req_t  rd_req;
	logic      rd_grant;
	ram_req_t  mem_req;
	pix_word_t rd_data;

	// ------------------------------------------------------------------------
	// write side
	// ------------------------------------------------------------------------
	blk_row_sequencer i_blk_row_sequencer (
		.clk          (clk),
		.reset_n      (reset_n),
		.row_valid    (row_valid),
		.row_data     (row_data),
		.mb_h         (mb_h),
		.mb_v         (mb_v),
		.pos          (pos),
		.pos_valid    (pos_valid),
		.pos_data     (pos_data),
		.end_of_mb    (end_of_mb),
		.end_of_frame (end_of_frame)
	);

	frame_addr_gen i_frame_addr_gen (
		.clk       (clk),
		.reset_n   (reset_n),
		.pos       (pos),
		.pos_valid (pos_valid),
		.pos_data  (pos_data),
		.wr_req    (wr_req)
	);

	// ------------------------------------------------------------------------
	// host read side
	// ------------------------------------------------------------------------
	apb_frame_reader i_apb_frame_reader (
		.clk      (clk),
		.reset_n  (reset_n),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.rd_req   (rd_req),
		.rd_grant (rd_grant),
		.rd_data  (rd_data)
	);

	// shared RAM port
	frame_ram_arbiter i_frame_ram_arbiter (
		.wr_req   (wr_req),
		.rd_req   (rd_req),
		.rd_grant (rd_grant),
		.mem_req  (mem_req)
	);

	frame_ram i_frame_ram (
		.clk     (clk),
		.mem_req (mem_req),
		.rd_data (rd_data)
	);

endmodule

/* logic/frame_ram.sv */
// single port, one read or write per cycle, read data one cycle later
// read during write returns the old word
`timescale 1ns/1ps

module frame_ram
	import frame_pkg::*;
(
	input  logic      clk,
	input  ram_req_t  mem_req,
	output pix_word_t rd_data
);

	pix_word_t mem [FRAME_WORDS];

	always_ff @(posedge clk)
	begin
		if (mem_req.en)
		begin
			if (mem_req.we)
				mem[mem_req.addr] <= mem_req.data;
			rd_data <= mem[mem_req.addr];    // registered output
		end
	end

endmodule

/* logic/frame_ram_arbiter.sv */
// fixed priority, the row writer always wins and the reader waits
`timescale 1ns/1ps

module frame_ram_arbiter
	import frame_pkg::*;
(
	input  ram_req_t wr_req,
	input  ram_req_t rd_req,
	output logic     rd_grant,
	output ram_req_t mem_req
);

	logic wr_wins;

	assign wr_wins  = wr_req.en;
	assign rd_grant = rd_req.en && !wr_wins;

	// ------------------------------------------------------------------------
	// port select
	// ------------------------------------------------------------------------
	always_comb
	begin
		if (wr_wins)
			mem_req = wr_req;
		else
			mem_req = rd_req;     // en low here when no one asks
	end

	// writer address and reader range check together keep the port in bounds
	always_comb
	begin
		if (mem_req.en)
			a_mem_addr_in_frame: assert final (mem_req.addr < frame_addr_t'(FRAME_WORDS));
	end

endmodule

/* logic/apb_frame_reader.sv */
// read-only APB slave, paddr is a byte address and bits 1:0 are ignored
// writes and words at or above FRAME_WORDS end in the first access cycle with pslverr
// transfers must run to pready; psel is not expected to drop early
`timescale 1ns/1ps

module apb_frame_reader
	import frame_pkg::*;
(
	input  logic        clk,
	input  logic        reset_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [15:0] paddr,
	input  pix_word_t   pwdata,
	output pix_word_t   prdata,
	output logic        pready,
	output logic        pslverr,
	output ram_req_t    rd_req,
	input  logic        rd_grant,
	input  pix_word_t   rd_data
);

	typedef enum logic [1:0] {
		st_idle,
		st_wait_gnt,
		st_data,
		st_done       // error response
	} rd_state_t;

	rd_state_t   state;
	frame_addr_t word_addr;
	logic        bad_xfer;
	pix_word_t   prdata_q;

	assign word_addr = paddr[15:2];
	assign bad_xfer  = pwrite || (word_addr >= frame_addr_t'(FRAME_WORDS));

	// decoded on the setup phase so the answer is ready in the access phase
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			state <= st_idle;
		else
		begin
			case (state)
				st_idle:
					if (psel && !penable)
						state <= bad_xfer ? st_done : st_wait_gnt;
				st_wait_gnt:
					if (rd_grant)
						state <= st_data;
				st_data:
					state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	// ram word arrives the cycle after the grant
	always_ff @(posedge clk)
	begin
		if (state == st_data)
			prdata_q <= rd_data;
	end

	assign prdata  = (state == st_data) ? rd_data : prdata_q;
	assign pready  = (state == st_data) || (state == st_done);
	assign pslverr = (state == st_done);

	always_comb
	begin
		rd_req.en   = (state == st_wait_gnt);
		rd_req.we   = 1'b0;
		rd_req.addr = word_addr;
		rd_req.data = pwdata;    // ignored by the RAM, we is low
	end

endmodule

/* logic/frame_addr_gen.sv */
// bypass write addressing, rows must follow the sequencer order
// left-top of a plane is taken at blocks 0, 16 and 20; later rows step by stride
`timescale 1ns/1ps

module frame_addr_gen
	import frame_pkg::*;
(
	input  logic      clk,
	input  logic      reset_n,
	input  blk_pos_t  pos,
	input  logic      pos_valid,
	input  pix_word_t pos_data,
	output ram_req_t  wr_req
);

	logic        is_luma;
	logic        is_cr;
	logic        plane_first;   // first row of the plane's first block
	frame_addr_t lt_luma;
	frame_addr_t lt_chroma;
	frame_addr_t lt_calc;
	frame_addr_t left_top;
	frame_addr_t blk_off;
	frame_addr_t stride;
	frame_addr_t row_addr;
	frame_addr_t left_top_q;
	frame_addr_t prev_addr_q;

	// blk[4] chroma, blk[2] Cr, luma blocks in raster order
	assign is_luma = !pos.blk[4];
	assign is_cr   = pos.blk[4] && pos.blk[2];
	assign stride  = is_luma ? LUMA_STRIDE : CHROMA_STRIDE;

	assign plane_first = pos.first &&
		(is_luma ? (pos.blk[3:0] == 4'd0) : (pos.blk[1:0] == 2'd0));

	// ------------------------------------------------------------------------
	// left-top word of the macroblock in its plane
	// ------------------------------------------------------------------------
	assign lt_luma = frame_addr_t'({pos.mb_h, 2'b00})
		+ frame_addr_t'({pos.mb_v, 4'b0000}) * LUMA_STRIDE;   // 16 pixel rows per mb

	assign lt_chroma = (is_cr ? CR_BASE : CB_BASE)
		+ frame_addr_t'({pos.mb_h, 1'b0})
		+ frame_addr_t'({pos.mb_v, 3'b000}) * CHROMA_STRIDE;  // 8 chroma rows per mb

	assign lt_calc  = is_luma ? lt_luma : lt_chroma;
	assign left_top = plane_first ? lt_calc : left_top_q;

	// block offset inside the macroblock
	always_comb
	begin
		if (is_luma)
			blk_off = frame_addr_t'(pos.blk[1:0])
				+ frame_addr_t'(pos.blk[3:2]) * frame_addr_t'(ROWS_PER_BLK) * LUMA_STRIDE;
		else if (pos.blk[1])
			blk_off = frame_addr_t'(pos.blk[0])
				+ frame_addr_t'(ROWS_PER_BLK) * CHROMA_STRIDE;   // lower half, +88
		else
			blk_off = frame_addr_t'(pos.blk[0]);
	end

	// row 0 from the left-top, rows 1..3 one stride below the previous
	assign row_addr = pos.first ? (left_top + blk_off) : (prev_addr_q + stride);

	always_comb
	begin
		wr_req.en   = pos_valid;
		wr_req.we   = pos_valid;
		wr_req.addr = row_addr;
		wr_req.data = pos_data;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			left_top_q  <= '0;
			prev_addr_q <= '0;
		end
		else if (pos_valid)
		begin
			if (plane_first)
				left_top_q <= lt_calc;
			prev_addr_q <= row_addr;
		end
	end

	a_wr_addr_in_frame: assert property (@(posedge clk) disable iff (!reset_n)
		wr_req.en |-> (wr_req.addr < frame_addr_t'(FRAME_WORDS)));

endmodule

/* logic/blk_row_sequencer.sv */
// rows must arrive block 0..23, rows 0..3 inside each block, no back-pressure
// mb_h / mb_v are sampled with the first row of a macroblock only
`timescale 1ns/1ps

module blk_row_sequencer
	import frame_pkg::*;
(
	input  logic      clk,
	input  logic      reset_n,
	input  logic      row_valid,
	input  pix_word_t row_data,
	input  mb_num_t   mb_h,
	input  mb_num_t   mb_v,
	output blk_pos_t  pos,
	output logic      pos_valid,
	output pix_word_t pos_data,
	output logic      end_of_mb,
	output logic      end_of_frame
);

	blk_idx_t blk_cnt;
	row_idx_t row_cnt;
	mb_num_t  mb_h_q;
	mb_num_t  mb_v_q;
	logic     mb_first;   // incoming row opens a macroblock
	logic     blk_last_row;
	logic     mb_last_row;
	logic     last_row_q; // 96th row went out on pos this cycle
	logic     last_mb;

	assign mb_first     = (blk_cnt == '0) && (row_cnt == '0);
	assign blk_last_row = (row_cnt == row_idx_t'(ROWS_PER_BLK - 1));
	assign mb_last_row  = blk_last_row && (blk_cnt == blk_idx_t'(BLKS_PER_MB - 1));

	// position of the row currently on pos, i.e. the latched one
	assign last_mb = (pos.mb_h == mb_num_t'(LAST_MB_H)) && (pos.mb_v == mb_num_t'(LAST_MB_V));

	// ------------------------------------------------------------------------
	// block / row counters and macroblock position latch
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			blk_cnt <= '0;
			row_cnt <= '0;
			mb_h_q  <= '0;
			mb_v_q  <= '0;
		end
		else if (row_valid)
		begin
			row_cnt <= row_cnt + 1'b1;    // wraps after row 3
			if (blk_last_row)
				blk_cnt <= mb_last_row ? '0 : blk_cnt + 1'b1;
			if (mb_first)
			begin
				mb_h_q <= mb_h;
				mb_v_q <= mb_v;
			end
		end
	end

	// payload towards the address generator
	always_ff @(posedge clk)
	begin
		if (row_valid)
		begin
			pos.mb_h  <= mb_first ? mb_h : mb_h_q;
			pos.mb_v  <= mb_first ? mb_v : mb_v_q;
			pos.blk   <= blk_cnt;
			pos.row   <= row_cnt;
			pos.first <= (row_cnt == '0);
			pos_data  <= row_data;
		end
	end

	// valid, then end pulses one cycle behind the last write
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			pos_valid    <= 1'b0;
			last_row_q   <= 1'b0;
			end_of_mb    <= 1'b0;
			end_of_frame <= 1'b0;
		end
		else
		begin
			pos_valid    <= row_valid;
			last_row_q   <= row_valid && mb_last_row;
			end_of_mb    <= last_row_q && !last_mb;
			end_of_frame <= last_row_q && last_mb;
		end
	end

	a_blk_in_range: assert property (@(posedge clk) disable iff (!reset_n)
		pos_valid |-> (pos.blk < blk_idx_t'(BLKS_PER_MB)));

endmodule

/* logic/frame_pkg.sv */
// QCIF display frame geometry, 11 x 9 macroblocks, 4:2:0, four pixels per word
// plane order in the RAM is luma, then Cb, then Cr, all in raster order
package frame_pkg;

	// ------------------------------------------------------------------------
	// frame geometry
	// ------------------------------------------------------------------------
	localparam int MB_COLS      = 11;
	localparam int MB_ROWS      = 9;
	localparam int LAST_MB_H    = 10;
	localparam int LAST_MB_V    = 8;
	localparam int BLKS_PER_MB  = 24;     // 16 luma, 4 Cb, 4 Cr
	localparam int ROWS_PER_BLK = 4;
	localparam int ADDR_W       = 14;
	localparam int FRAME_WORDS  = 9504;

	typedef logic [3:0]        mb_num_t;
	typedef logic [4:0]        blk_idx_t;
	typedef logic [1:0]        row_idx_t;
	typedef logic [31:0]       pix_word_t;   // pixel 0 in bits 7:0
	typedef logic [ADDR_W-1:0] frame_addr_t;

	// word strides and plane bases
	localparam frame_addr_t LUMA_STRIDE   = frame_addr_t'(MB_COLS * 4);
	localparam frame_addr_t CHROMA_STRIDE = frame_addr_t'(MB_COLS * 2);
	localparam frame_addr_t CB_BASE       = 14'd6336;
	localparam frame_addr_t CR_BASE       = 14'd7920;

	// ------------------------------------------------------------------------
	// shared structs
	// ------------------------------------------------------------------------

	// where a row belongs, as seen by the address generator
	typedef struct packed {
		mb_num_t  mb_h;
		mb_num_t  mb_v;
		blk_idx_t blk;
		row_idx_t row;
		logic     first;     // row 0 of its block
	} blk_pos_t;

	// one access on the single RAM port
	typedef struct packed {
		logic        en;
		logic        we;
		frame_addr_t addr;
		pix_word_t   data;
	} ram_req_t;

endpackage
